//--- store_queue.f
+incdir+design
design/store_queue_pkg.sv
design/stq_entry_if.sv
design/stq_ctrl.sv
design/stq_entries.sv
design/ld_conflict_check.sv
design/wb_store_port.sv
design/store_queue.sv
tb/store_queue_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = store_queue_tb
FILELIST  = store_queue.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/store_queue_tb.sv
`timescale 1ns/1ps

module store_queue_tb;

  typedef enum logic [2:0] {
    op_store,
    op_commit,
    op_flush,
    op_load,
    op_drain,
    op_ready
  } op_t;

  typedef struct packed {
    op_t op;
    logic [31:0] addr;
    logic [1:0] size;
    logic [31:0] data;
    logic exp_bit;  // expected ld_conflict or st_ready
  } row_t;

  localparam int max_wait = 200;

  logic clk = 1'b0;
  logic reset;
  logic st_valid;
  logic st_ready;
  logic [31:0] st_addr;
  logic [1:0] st_size;
  logic [31:0] st_data;
  logic commit;
  logic flush;
  logic [31:0] ld_addr;
  logic [1:0] ld_size;
  logic ld_conflict;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic [3:0] wb_sel;
  logic wb_ack = 1'b0;

  integer seed = 32'h28685405;
  int ack_delay;
  bit in_cycle = 1'b0;
  logic [31:0] cur_adr;
  logic [31:0] cur_dat;
  logic [3:0] cur_sel;
  logic [31:0] adr_log [$];  // completed bus writes
  logic [31:0] dat_log [$];
  logic [3:0] sel_log [$];
  row_t rows [$];

  store_queue uut (
    .clk(clk), .reset(reset),
    .st_valid(st_valid), .st_ready(st_ready),
    .st_addr(st_addr), .st_size(st_size), .st_data(st_data),
    .commit(commit), .flush(flush),
    .ld_addr(ld_addr), .ld_size(ld_size), .ld_conflict(ld_conflict),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_sel(wb_sel), .wb_ack(wb_ack)
  );

  always #10 clk = ~clk;

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  endtask

  // lanes covered by an access aligned down to its size
  function automatic logic [3:0] lanes_of(input logic [31:0] addr, input logic [1:0] size);
    int n;
    int start;
    logic [3:0] s;
    n = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    start = int'(addr[1:0]) & ~(n - 1);
    s = '0;
    for (int b = 0; b < 4; b++)
      if (b >= start && b < start + n) s[b] = 1'b1;
    return s;
  endfunction

  function automatic logic [31:0] lane_data(input logic [31:0] addr, input logic [1:0] size,
                                            input logic [31:0] data);
    logic [3:0] s;
    logic [31:0] d;
    int k;
    s = lanes_of(addr, size);
    d = '0;
    k = 0;
    for (int b = 0; b < 4; b++)
      if (s[b]) begin
        d[8*b +: 8] = data[8*k +: 8];  // low store bytes in order
        k++;
      end
    return d;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] s);
    logic [31:0] m;
    for (int b = 0; b < 4; b++)
      m[8*b +: 8] = {8{s[b]}};
    return m;
  endfunction

  task automatic add_row(input op_t op, input logic [31:0] addr, input logic [1:0] size,
                         input logic [31:0] data, input logic exp_bit);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.size = size;
    r.data = data;
    r.exp_bit = exp_bit;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // mixed sizes with junk in the upper data bits
    add_row(op_store, 32'h101, 2'd0, 32'h123456ab, 1'b0);
    add_row(op_store, 32'h106, 2'd1, 32'hffff1234, 1'b0);
    add_row(op_store, 32'h108, 2'd2, 32'hdeadbeef, 1'b0);
    add_row(op_store, 32'h10e, 2'd3, 32'hcafef00d, 1'b0);
    add_row(op_store, 32'h113, 2'd1, 32'h00005678, 1'b0);
    add_row(op_load, 32'h101, 2'd0, 32'h0, 1'b1);
    add_row(op_load, 32'h100, 2'd0, 32'h0, 1'b0);  // same word but other byte
    add_row(op_load, 32'h104, 2'd1, 32'h0, 1'b0);
    add_row(op_load, 32'h10c, 2'd0, 32'h0, 1'b1);
    add_row(op_load, 32'h112, 2'd0, 32'h0, 1'b1);
    add_row(op_load, 32'h114, 2'd2, 32'h0, 1'b0);
    for (int i = 0; i < 5; i++)
      add_row(op_commit, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_drain, 32'h101, 2'd0, 32'h123456ab, 1'b0);
    add_row(op_drain, 32'h106, 2'd1, 32'hffff1234, 1'b0);
    add_row(op_drain, 32'h108, 2'd2, 32'hdeadbeef, 1'b0);
    add_row(op_drain, 32'h10e, 2'd3, 32'hcafef00d, 1'b0);
    add_row(op_drain, 32'h113, 2'd1, 32'h00005678, 1'b0);
    add_row(op_load, 32'h108, 2'd2, 32'h0, 1'b0);  // drained
    // flush drops the two younger stores
    add_row(op_store, 32'h200, 2'd2, 32'h11111111, 1'b0);
    add_row(op_commit, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_store, 32'h204, 2'd2, 32'h22222222, 1'b0);
    add_row(op_store, 32'h209, 2'd0, 32'h00000033, 1'b0);
    add_row(op_load, 32'h204, 2'd2, 32'h0, 1'b1);
    add_row(op_flush, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_load, 32'h204, 2'd2, 32'h0, 1'b0);
    add_row(op_load, 32'h209, 2'd0, 32'h0, 1'b0);
    add_row(op_store, 32'h20e, 2'd1, 32'h00004444, 1'b0);
    add_row(op_commit, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_drain, 32'h200, 2'd2, 32'h11111111, 1'b0);
    add_row(op_drain, 32'h20e, 2'd1, 32'h00004444, 1'b0);
    // fill the queue and drain it under random ack delays
    for (int i = 0; i < 8; i++)
      add_row(op_store, 32'h300 + 4 * i, 2'd2, 32'ha0000000 + i, 1'b0);
    add_row(op_ready, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_load, 32'h31c, 2'd2, 32'h0, 1'b1);
    add_row(op_commit, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_drain, 32'h300, 2'd2, 32'ha0000000, 1'b0);
    add_row(op_ready, 32'h0, 2'd0, 32'h0, 1'b1);
    for (int i = 1; i < 8; i++)
      add_row(op_commit, 32'h0, 2'd0, 32'h0, 1'b0);
    add_row(op_load, 32'h31c, 2'd2, 32'h0, 1'b1);  // committed, still queued
    for (int i = 1; i < 8; i++)
      add_row(op_drain, 32'h300 + 4 * i, 2'd2, 32'ha0000000 + i, 1'b0);
  endtask

  // starts and ends on a falling edge
  task automatic apply_row(input row_t r);
    int waited;
    logic [3:0] s;
    waited = 0;
    s = lanes_of(r.addr, r.size);
    case (r.op)
      op_store: begin
        st_valid = 1'b1;
        st_addr = r.addr;
        st_size = r.size;
        st_data = r.data;
        while (!st_ready) begin
          @(negedge clk);
          waited++;
          if (waited > max_wait) report_timeout("store was never accepted");
        end
        @(negedge clk);
        st_valid = 1'b0;
      end
      op_commit, op_flush: begin
        commit = (r.op == op_commit);
        flush = (r.op == op_flush);
        @(negedge clk);
        commit = 1'b0;
        flush = 1'b0;
      end
      op_load: begin
        ld_addr = r.addr;
        ld_size = r.size;
        #5;
        check_eq(32'(ld_conflict), 32'(r.exp_bit), "ld_conflict");
        @(negedge clk);
      end
      op_drain: begin
        while (adr_log.size() == 0) begin
          @(negedge clk);
          waited++;
          if (waited > max_wait) report_timeout("no bus write completed");
        end
        check_eq(adr_log.pop_front(), {r.addr[31:2], 2'b00}, "wb_adr");
        check_eq(32'(sel_log.pop_front()), 32'(s), "wb_sel");
        check_eq(dat_log.pop_front() & byte_mask(s), lane_data(r.addr, r.size, r.data),
                 "wb_dat");
      end
      default:
        check_eq(32'(st_ready), 32'(r.exp_bit), "st_ready");
    endcase
  endtask

  // wishbone slave acking after 0 to 3 idle cycles
  always @(negedge clk) begin
    if (reset) begin
      wb_ack = 1'b0;
      in_cycle = 1'b0;
    end else begin
      check_eq(32'(wb_stb), 32'(wb_cyc), "wb_stb");
      check_eq(32'(wb_we), 32'(wb_cyc), "wb_we");
      if (wb_ack) begin
        check_eq(32'(wb_cyc), 32'd0, "wb_cyc after ack");
        wb_ack = 1'b0;
        in_cycle = 1'b0;
        adr_log.push_back(cur_adr);
        dat_log.push_back(cur_dat);
        sel_log.push_back(cur_sel);
      end else if (wb_cyc) begin
        if (!in_cycle) begin
          in_cycle = 1'b1;
          cur_adr = wb_adr;
          cur_dat = wb_dat;
          cur_sel = wb_sel;
          ack_delay = $random(seed) & 3;
        end else begin
          check_eq(wb_adr, cur_adr, "wb_adr held");
          check_eq(wb_dat, cur_dat, "wb_dat held");
          check_eq(32'(wb_sel), 32'(cur_sel), "wb_sel held");
        end
        if (ack_delay == 0)
          wb_ack = 1'b1;
        else
          ack_delay--;
      end
    end
  end

  initial begin
    reset = 1'b1;
    st_valid = 1'b0;
    st_addr = '0;
    st_size = '0;
    st_data = '0;
    commit = 1'b0;
    flush = 1'b0;
    ld_addr = '0;
    ld_size = '0;
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_eq(32'(wb_cyc), 32'd0, "wb_cyc after reset");
    check_eq(32'(wb_stb), 32'd0, "wb_stb after reset");
    check_eq(32'(st_ready), 32'd1, "st_ready after reset");
    foreach (rows[i])
      apply_row(rows[i]);
    repeat (20) @(negedge clk);  // nothing left may reach the bus
    check_eq(32'(adr_log.size()), 32'd0, "extra bus writes");
    check_eq(32'(wb_cyc), 32'd0, "wb_cyc at end");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- design/store_queue.sv
`timescale 1ns/1ps

module store_queue (
  input  logic clk,
  input  logic reset,

  // from the address unit
  input  logic st_valid,
  output logic st_ready,
  input  store_queue_pkg::addr_t st_addr,
  input  store_queue_pkg::size_t st_size,
  input  store_queue_pkg::data_t st_data,

  // retirement
  input  logic commit,
  input  logic flush,

  input  store_queue_pkg::addr_t ld_addr,
  input  store_queue_pkg::size_t ld_size,
  output logic ld_conflict,

  // wishbone master
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output store_queue_pkg::addr_t wb_adr,
  output store_queue_pkg::data_t wb_dat,
  output store_queue_pkg::sel_t wb_sel,
  input  logic wb_ack
);

  logic launch;

  stq_entry_if ent_if ();

  stq_ctrl ctrl (
    .clk(clk),
    .reset(reset),
    .st_valid(st_valid),
    .st_ready(st_ready),
    .commit(commit),
    .flush(flush),
    .wb_ack(wb_ack),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .launch(launch),
    .ent(ent_if.ctrl)
  );

  stq_entries entries (
    .clk(clk),
    .st_addr(st_addr),
    .st_size(st_size),
    .st_data(st_data),
    .ent(ent_if.entries)
  );

  ld_conflict_check ld_check (
    .ld_addr(ld_addr),
    .ld_size(ld_size),
    .ld_conflict(ld_conflict),
    .ent(ent_if.check)
  );

  wb_store_port bus_port (
    .clk(clk),
    .reset(reset),
    .launch(launch),
    .wb_adr(wb_adr),
    .wb_dat(wb_dat),
    .wb_sel(wb_sel),
    .ent(ent_if.port)
  );

endmodule

//--- design/wb_store_port.sv
`timescale 1ns/1ps
`include "store_queue_macros.svh"

module wb_store_port (
  input  logic clk,
  input  logic reset,
  input  logic launch,
  output store_queue_pkg::addr_t wb_adr,
  output store_queue_pkg::data_t wb_dat,
  output store_queue_pkg::sel_t wb_sel,
  stq_entry_if.port ent
);

  store_queue_pkg::addr_t adr_q;
  store_queue_pkg::data_t dat_q;
  store_queue_pkg::sel_t sel_q;

  // held for the whole cycle, head may not move until ack
  always_ff @(posedge clk) begin
    if (launch) begin
      adr_q <= {ent.rd_word[`STQ_ADDR_W-1:2], 2'b00};
      dat_q <= ent.rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      sel_q <= '0;  // no lanes until first write
    else if (launch)
      sel_q <= ent.rd_sel;
  end

  assign wb_adr = adr_q;
  assign wb_dat = dat_q;
  assign wb_sel = sel_q;

endmodule

//--- design/ld_conflict_check.sv
`timescale 1ns/1ps
`include "store_queue_macros.svh"

module ld_conflict_check (
  input  store_queue_pkg::addr_t ld_addr,
  input  store_queue_pkg::size_t ld_size,
  output logic ld_conflict,
  stq_entry_if.check ent
);

  store_queue_pkg::addr_t ld_word;
  store_queue_pkg::sel_t ld_sel;
  store_queue_pkg::mask_t hit;

  assign ld_word = {ld_addr[`STQ_ADDR_W-1:2], 2'b00};
  assign ld_sel = store_queue_pkg::size_to_sel(ld_size, ld_addr[1:0]);

  // committed or not, any valid store with a shared byte
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      hit[i] = ent.valid[i] && (ent.word_addr[i] == ld_word) &&
               |(ent.sel[i] & ld_sel);
    end
  end

  assign ld_conflict = |hit;

endmodule

//--- design/stq_entries.sv
`timescale 1ns/1ps
`include "store_queue_macros.svh"

module stq_entries (
  input logic clk,
  input store_queue_pkg::addr_t st_addr,
  input store_queue_pkg::size_t st_size,
  input store_queue_pkg::data_t st_data,
  stq_entry_if.entries ent
);

  store_queue_pkg::addr_t word_q [`STQ_DEPTH];
  store_queue_pkg::sel_t sel_q [`STQ_DEPTH];
  store_queue_pkg::data_t data_q [`STQ_DEPTH];

  store_queue_pkg::addr_t wr_word;
  store_queue_pkg::sel_t wr_sel;
  store_queue_pkg::data_t wr_lane;

  assign wr_word = {st_addr[`STQ_ADDR_W-1:2], 2'b00};
  assign wr_sel = store_queue_pkg::size_to_sel(st_size, st_addr[1:0]);

  // move the store data onto its byte lanes
  always_comb begin
    case (st_size)
      2'd0:
        wr_lane = store_queue_pkg::data_t'(st_data[7:0]) << {st_addr[1:0], 3'b000};
      2'd1:
        wr_lane = store_queue_pkg::data_t'(st_data[15:0]) << {st_addr[1], 4'b0000};
      default:
        wr_lane = st_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ent.wr_en) begin
      word_q[ent.wr_idx] <= wr_word;
      sel_q[ent.wr_idx] <= wr_sel;
      data_q[ent.wr_idx] <= wr_lane;
    end
  end

  // head entry for the bus port
  assign ent.rd_word = word_q[ent.rd_idx];
  assign ent.rd_data = data_q[ent.rd_idx];
  assign ent.rd_sel = sel_q[ent.rd_idx];

  assign ent.word_addr = word_q;
  assign ent.sel = sel_q;

endmodule

//--- design/stq_ctrl.sv
`timescale 1ns/1ps
`include "store_queue_macros.svh"

module stq_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic st_valid,
  output logic st_ready,
  input  logic commit,
  input  logic flush,
  input  logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic launch,
  stq_entry_if.ctrl ent
);

  store_queue_pkg::ptr_t head;  // oldest entry, next to drain
  store_queue_pkg::ptr_t cmt;   // oldest uncommitted
  store_queue_pkg::ptr_t tail;  // next free slot

  store_queue_pkg::idx_t head_idx;
  store_queue_pkg::idx_t cmt_idx;
  store_queue_pkg::idx_t tail_idx;

  store_queue_pkg::mask_t valid;
  store_queue_pkg::mask_t done;  // committed entries
  store_queue_pkg::mask_t valid_nxt;
  store_queue_pkg::mask_t done_nxt;

  store_queue_pkg::wb_state_t state;

  logic full;
  logic accept;
  logic do_commit;
  logic free;

  assign head_idx = store_queue_pkg::idx_t'(head);
  assign cmt_idx = store_queue_pkg::idx_t'(cmt);
  assign tail_idx = store_queue_pkg::idx_t'(tail);

  // same slot, opposite wrap bit
  assign full = (head ^ tail) == store_queue_pkg::ptr_t'(`STQ_DEPTH);
  assign st_ready = ~full;

  // a store arriving with the flush is younger than the exception
  assign accept = st_valid & ~full & ~flush;
  assign do_commit = commit & ~flush & (cmt != tail);
  assign free = (state == store_queue_pkg::busy) & wb_ack;
  assign launch = (state == store_queue_pkg::idle) & done[head_idx];

  always_comb begin
    valid_nxt = valid;
    done_nxt = done;
    if (accept)
      valid_nxt[tail_idx] = 1'b1;
    if (do_commit)
      done_nxt[cmt_idx] = 1'b1;
    if (flush)
      valid_nxt = valid & done;  // keep committed only
    if (free) begin
      valid_nxt[head_idx] = 1'b0;
      done_nxt[head_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head <= '0;
      cmt <= '0;
      tail <= '0;
      valid <= '0;
      done <= '0;
      state <= store_queue_pkg::idle;
    end else begin
      if (flush)
        tail <= cmt;
      else if (accept)
        tail <= tail + 1'b1;
      if (do_commit)
        cmt <= cmt + 1'b1;
      if (free)
        head <= head + 1'b1;
      valid <= valid_nxt;
      done <= done_nxt;

      case (state)
        store_queue_pkg::idle:
          if (launch)
            state <= store_queue_pkg::busy;
        store_queue_pkg::busy:
          if (wb_ack)
            state <= store_queue_pkg::idle;  // at least one idle cycle
        default:
          state <= store_queue_pkg::idle;
      endcase
    end
  end

  // classic single write, strobe follows cycle
  assign wb_cyc = (state == store_queue_pkg::busy);
  assign wb_stb = wb_cyc;
  assign wb_we = wb_cyc;

  assign ent.wr_en = accept;
  assign ent.wr_idx = tail_idx;
  assign ent.rd_idx = head_idx;
  assign ent.valid = valid;

endmodule

//--- design/stq_entry_if.sv
`timescale 1ns/1ps
`include "store_queue_macros.svh"

interface stq_entry_if;

  logic wr_en;
  store_queue_pkg::idx_t wr_idx;
  store_queue_pkg::idx_t rd_idx;
  store_queue_pkg::mask_t valid;

  // head entry
  store_queue_pkg::addr_t rd_word;
  store_queue_pkg::data_t rd_data;
  store_queue_pkg::sel_t rd_sel;

  // per-entry view for the load check
  store_queue_pkg::addr_t word_addr [`STQ_DEPTH];
  store_queue_pkg::sel_t sel [`STQ_DEPTH];

  modport ctrl (output wr_en, output wr_idx, output rd_idx, output valid);

  modport entries (
    input wr_en, input wr_idx, input rd_idx,
    output rd_word, output rd_data, output rd_sel,
    output word_addr, output sel
  );

  modport check (input word_addr, input sel, input valid);

  modport port (input rd_word, input rd_data, input rd_sel);

endinterface

//--- design/store_queue_pkg.sv
`include "store_queue_macros.svh"

package store_queue_pkg;

  typedef logic [`STQ_ADDR_W-1:0] addr_t;
  typedef logic [`STQ_DATA_W-1:0] data_t;
  typedef logic [`STQ_DATA_W/8-1:0] sel_t;
  typedef logic [1:0] size_t;  // 0 byte, 1 half, 2/3 word

  typedef logic [$clog2(`STQ_DEPTH)-1:0] idx_t;
  typedef logic [$clog2(`STQ_DEPTH):0] ptr_t;  // extra wrap bit
  typedef logic [`STQ_DEPTH-1:0] mask_t;

  typedef enum logic {
    idle,
    busy
  } wb_state_t;

  // byte lanes touched by an aligned access
  function automatic sel_t size_to_sel(size_t size, logic [1:0] low);
    sel_t sel;
    case (size)
      2'd0: sel = sel_t'(4'b0001) << low;
      2'd1: sel = low[1] ? 4'b1100 : 4'b0011;  // low[0] ignored
      default: sel = 4'b1111;
    endcase
    return sel;
  endfunction

endpackage

//--- design/store_queue_macros.svh
`ifndef STORE_QUEUE_MACROS_SVH
`define STORE_QUEUE_MACROS_SVH

// entries in the queue, power of two
`define STQ_DEPTH 8

// byte address width
`define STQ_ADDR_W 32

// bus data width
`define STQ_DATA_W 32

`endif
